// ==== hw/oneplus_pkg.sv ====
// Shared types and constants for the matrix oneplus unit
// Fixed point is Q.8 and the residual table assumes exactly 8 fraction bits
// Residual is piecewise constant over |x| in [0, 4) with no interpolation

package oneplus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Control states
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    STREAM = 2'd1,
    DRAIN  = 2'd2
  } ctrl_state_t;

  ////////////////////////////////////////////////////////////////////////////
  // Fixed-point constants
  ////////////////////////////////////////////////////////////////////////////

  localparam int FRAC_BITS = 8;
  // 1.0 in Q.8
  localparam int ONE_FIXED = 256;
  // 4.0 in Q.8, residual is zero from here on
  localparam int RES_LIMIT = 1024;

  ////////////////////////////////////////////////////////////////////////////
  // Residual table
  ////////////////////////////////////////////////////////////////////////////

  // ln(1 + e^-a) in Q.8, sampled at the low end of each quarter bin
  function automatic logic [7:0] residual_lut(input logic [3:0] idx);
    case (idx)
      4'd0:    return 8'd177;
      4'd1:    return 8'd147;
      4'd2:    return 8'd121;
      4'd3:    return 8'd99;
      4'd4:    return 8'd80;
      4'd5:    return 8'd64;
      4'd6:    return 8'd52;
      4'd7:    return 8'd41;
      4'd8:    return 8'd32;
      4'd9:    return 8'd26;
      4'd10:   return 8'd20;
      4'd11:   return 8'd16;
      4'd12:   return 8'd12;
      4'd13:   return 8'd10;
      4'd14:   return 8'd8;
      default: return 8'd6;
    endcase
  endfunction

endpackage

// ==== hw/oneplus_matrix_ctrl.sv ====
// Index walker and credit manager for the oneplus matrix unit
// Source must hold an input credit for every in_valid it sends
// OUT_CREDITS must lie between 1 and 15, rows and cols are sampled at start
// A zero dimension gives a done pulse with no credits granted

`timescale 1ns/100ps

module oneplus_matrix_ctrl
  import oneplus_pkg::*;
#(
  parameter int DATA_SIZE   = 16,
  parameter int DIM_WIDTH   = 8,
  parameter int OUT_CREDITS = 4
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 start,
  input  logic [DIM_WIDTH-1:0] rows,
  input  logic [DIM_WIDTH-1:0] cols,
  input  logic                 in_valid,
  input  logic [DATA_SIZE-1:0] in_data,
  input  logic                 out_credit,
  input  logic                 out_valid,
  input  logic                 out_last,
  output logic                 in_credit,
  output logic                 elem_valid,
  output logic [DATA_SIZE-1:0] elem_data,
  output logic                 elem_row_end,
  output logic                 elem_last,
  output logic                 busy,
  output logic                 done
);

  // Credit counters never exceed 15
  localparam int CW = 4;

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  ctrl_state_t              state;
  logic [DIM_WIDTH-1:0]     rows_q;
  logic [DIM_WIDTH-1:0]     cols_q;
  logic [DIM_WIDTH-1:0]     row_idx;
  logic [DIM_WIDTH-1:0]     col_idx;
  logic [DIM_WIDTH-1:0]     row_max;
  logic [DIM_WIDTH-1:0]     col_max;
  logic [2*DIM_WIDTH-1:0]   total;
  logic [2*DIM_WIDTH-1:0]   granted;
  logic [CW-1:0]            out_cnt;
  // Input credits granted but not yet used by the source
  logic [CW-1:0]            in_pend;
  logic                     grant;

  assign total   = rows_q * cols_q;
  assign row_max = rows_q - 1'b1;
  assign col_max = cols_q - 1'b1;

  // One grant per cycle, needs a free output slot
  assign grant = (state == STREAM) && (granted != total) && (out_cnt != '0);

  ////////////////////////////////////////////////////////////////////////////
  // Element tagging
  ////////////////////////////////////////////////////////////////////////////

  assign elem_valid   = in_valid;
  assign elem_data    = in_data;
  assign elem_row_end = (col_idx == col_max);
  assign elem_last    = elem_row_end && (row_idx == row_max);

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= IDLE;
      busy      <= 1'b0;
      done      <= 1'b0;
      in_credit <= 1'b0;
      rows_q    <= '0;
      cols_q    <= '0;
      granted   <= '0;
    end else begin
      done      <= 1'b0;
      in_credit <= grant;
      case (state)
        IDLE: begin
          if (start) begin
            rows_q  <= rows;
            cols_q  <= cols;
            granted <= '0;
            // Empty matrix finishes at once
            if ((rows == '0) || (cols == '0)) begin
              done <= 1'b1;
            end else begin
              busy  <= 1'b1;
              state <= STREAM;
            end
          end
        end
        STREAM: begin
          if (grant) begin
            granted <= granted + 1'b1;
            if ((granted + 1'b1) == total) begin
              state <= DRAIN;
            end
          end
        end
        DRAIN: begin
          // Wait for the tagged last element at the output
          if (out_valid && out_last) begin
            busy  <= 1'b0;
            done  <= 1'b1;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Row and column indices
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      row_idx <= '0;
      col_idx <= '0;
    end else if ((state == IDLE) && start) begin
      row_idx <= '0;
      col_idx <= '0;
    end else if (in_valid) begin
      if (col_idx == col_max) begin
        col_idx <= '0;
        row_idx <= row_idx + 1'b1;
      end else begin
        col_idx <= col_idx + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Credit counters
  ////////////////////////////////////////////////////////////////////////////

  // Sink returns slots with out_credit
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_cnt <= CW'(OUT_CREDITS);
      in_pend <= '0;
    end else begin
      out_cnt <= out_cnt + CW'(out_credit) - CW'(grant);
      in_pend <= in_pend + CW'(in_credit) - CW'(in_valid);
    end
  end

  // Source may only send against a credit it already holds
  a_credit_before_data: assert property (
    @(posedge CLK) disable iff (RST) in_valid |-> (in_pend != '0)
  );

  // Sink must not return more slots than it was given
  a_out_cnt_bound: assert property (
    @(posedge CLK) disable iff (RST) out_cnt <= CW'(OUT_CREDITS)
  );

endmodule

// ==== hw/oneplus_split.sv ====
// Stage 1 of the oneplus datapath
// Registers relu(x) and |x| with the most negative code saturated
// Never stalls, a new element may enter every cycle

`timescale 1ns/100ps

module oneplus_split #(
  parameter int DATA_SIZE = 16
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 elem_valid,
  input  logic [DATA_SIZE-1:0] elem_data,
  input  logic                 elem_row_end,
  input  logic                 elem_last,
  output logic                 s1_valid,
  output logic [DATA_SIZE-1:0] s1_relu,
  output logic [DATA_SIZE-1:0] s1_mag,
  output logic                 s1_row_end,
  output logic                 s1_last
);

  localparam logic [DATA_SIZE-1:0] MOST_NEG = {1'b1, {(DATA_SIZE-1){1'b0}}};
  localparam logic [DATA_SIZE-1:0] MAX_POS  = {1'b0, {(DATA_SIZE-1){1'b1}}};

  logic                 neg;
  logic [DATA_SIZE-1:0] mag_next;

  assign neg = elem_data[DATA_SIZE-1];

  // Two's complement negate, clamp the one code with no positive twin
  assign mag_next = (elem_data == MOST_NEG) ? MAX_POS :
                    neg ? (~elem_data + 1'b1) : elem_data;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid   <= 1'b0;
      s1_row_end <= 1'b0;
      s1_last    <= 1'b0;
    end else begin
      s1_valid   <= elem_valid;
      s1_row_end <= elem_row_end;
      s1_last    <= elem_last;
    end
  end

  // Payload
  always_ff @(posedge CLK) begin
    s1_relu <= neg ? '0 : elem_data;
    s1_mag  <= mag_next;
  end

endmodule

// ==== hw/oneplus_residual.sv ====
// Stage 2 of the oneplus datapath
// Looks up ln(1 + e^-|x|) from a 16 entry quarter-step table
// Residual is zero for |x| of 4.0 and above

`timescale 1ns/100ps

module oneplus_residual
  import oneplus_pkg::*;
#(
  parameter int DATA_SIZE = 16
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 s1_valid,
  input  logic [DATA_SIZE-1:0] s1_relu,
  input  logic [DATA_SIZE-1:0] s1_mag,
  input  logic                 s1_row_end,
  input  logic                 s1_last,
  output logic                 s2_valid,
  output logic [DATA_SIZE-1:0] s2_relu,
  output logic [7:0]           s2_res,
  output logic                 s2_row_end,
  output logic                 s2_last
);

  logic       in_range;
  logic [3:0] lut_idx;
  logic [7:0] res_next;

  assign in_range = (s1_mag < RES_LIMIT);

  // Two integer bits and two fraction bits give the quarter bin
  assign lut_idx = s1_mag[FRAC_BITS+1:FRAC_BITS-2];

  assign res_next = in_range ? residual_lut(lut_idx) : 8'd0;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s2_valid   <= 1'b0;
      s2_row_end <= 1'b0;
      s2_last    <= 1'b0;
    end else begin
      s2_valid   <= s1_valid;
      s2_row_end <= s1_row_end;
      s2_last    <= s1_last;
    end
  end

  // Payload
  always_ff @(posedge CLK) begin
    s2_relu <= s1_relu;
    s2_res  <= res_next;
  end

  // Largest table entry sits at index zero
  a_res_bound: assert property (
    @(posedge CLK) disable iff (RST) s2_valid |-> (s2_res <= residual_lut(4'd0))
  );

endmodule

// ==== hw/oneplus_sum.sv ====
// Stage 3 of the oneplus datapath
// out = relu + residual + 1.0, clamped to the largest positive code
// Output is registered and is never negative

`timescale 1ns/100ps

module oneplus_sum
  import oneplus_pkg::*;
#(
  parameter int DATA_SIZE = 16
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 s2_valid,
  input  logic [DATA_SIZE-1:0] s2_relu,
  input  logic [7:0]           s2_res,
  input  logic                 s2_row_end,
  input  logic                 s2_last,
  output logic                 out_valid,
  output logic [DATA_SIZE-1:0] out_data,
  output logic                 out_row_end,
  output logic                 out_last
);

  localparam logic [DATA_SIZE:0] SAT_MAX = {2'b00, {(DATA_SIZE-1){1'b1}}};

  // One extra bit so overflow past the signed range is visible
  logic [DATA_SIZE:0] sum_wide;

  assign sum_wide = {1'b0, s2_relu} + {{(DATA_SIZE-7){1'b0}}, s2_res}
                  + (DATA_SIZE+1)'(ONE_FIXED);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_valid   <= 1'b0;
      out_row_end <= 1'b0;
      out_last    <= 1'b0;
    end else begin
      out_valid   <= s2_valid;
      out_row_end <= s2_row_end;
      out_last    <= s2_last;
    end
  end

  // Saturate
  always_ff @(posedge CLK) begin
    out_data <= (sum_wide > SAT_MAX) ? SAT_MAX[DATA_SIZE-1:0] : sum_wide[DATA_SIZE-1:0];
  end

  a_out_nonneg: assert property (
    @(posedge CLK) disable iff (RST) out_valid |-> !out_data[DATA_SIZE-1]
  );

endmodule

// ==== hw/oneplus_top.sv ====
// Matrix oneplus unit, x -> 1 + ln(1 + e^x) on a row-major stream
// Credit flow on both sides, latency from accept to output is 3 cycles
// DATA_SIZE at least 12, OUT_CREDITS between 1 and 15

`timescale 1ns/100ps

module oneplus_top #(
  parameter int DATA_SIZE   = 16,
  parameter int DIM_WIDTH   = 8,
  parameter int OUT_CREDITS = 4
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 start,
  input  logic [DIM_WIDTH-1:0] rows,
  input  logic [DIM_WIDTH-1:0] cols,
  input  logic                 in_valid,
  input  logic [DATA_SIZE-1:0] in_data,
  input  logic                 out_credit,
  output logic                 in_credit,
  output logic                 out_valid,
  output logic [DATA_SIZE-1:0] out_data,
  output logic                 out_row_end,
  output logic                 out_last,
  output logic                 busy,
  output logic                 done
);

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline wires
  ////////////////////////////////////////////////////////////////////////////

  logic                 elem_valid;
  logic [DATA_SIZE-1:0] elem_data;
  logic                 elem_row_end;
  logic                 elem_last;

  logic                 s1_valid;
  logic [DATA_SIZE-1:0] s1_relu;
  logic [DATA_SIZE-1:0] s1_mag;
  logic                 s1_row_end;
  logic                 s1_last;

  logic                 s2_valid;
  logic [DATA_SIZE-1:0] s2_relu;
  logic [7:0]           s2_res;
  logic                 s2_row_end;
  logic                 s2_last;

  // Control also watches the output for the last tag
  oneplus_matrix_ctrl #(
    .DATA_SIZE  (DATA_SIZE),
    .DIM_WIDTH  (DIM_WIDTH),
    .OUT_CREDITS(OUT_CREDITS)
  ) u_ctrl (
    .CLK(CLK), .RST(RST), .start(start), .rows(rows), .cols(cols),
    .in_valid(in_valid), .in_data(in_data), .out_credit(out_credit),
    .out_valid(out_valid), .out_last(out_last), .in_credit(in_credit),
    .elem_valid(elem_valid), .elem_data(elem_data),
    .elem_row_end(elem_row_end), .elem_last(elem_last),
    .busy(busy), .done(done)
  );

  oneplus_split #(.DATA_SIZE(DATA_SIZE)) u_split (
    .CLK(CLK), .RST(RST), .elem_valid(elem_valid), .elem_data(elem_data),
    .elem_row_end(elem_row_end), .elem_last(elem_last),
    .s1_valid(s1_valid), .s1_relu(s1_relu), .s1_mag(s1_mag),
    .s1_row_end(s1_row_end), .s1_last(s1_last)
  );

  oneplus_residual #(.DATA_SIZE(DATA_SIZE)) u_residual (
    .CLK(CLK), .RST(RST), .s1_valid(s1_valid), .s1_relu(s1_relu),
    .s1_mag(s1_mag), .s1_row_end(s1_row_end), .s1_last(s1_last),
    .s2_valid(s2_valid), .s2_relu(s2_relu), .s2_res(s2_res),
    .s2_row_end(s2_row_end), .s2_last(s2_last)
  );

  oneplus_sum #(.DATA_SIZE(DATA_SIZE)) u_sum (
    .CLK(CLK), .RST(RST), .s2_valid(s2_valid), .s2_relu(s2_relu),
    .s2_res(s2_res), .s2_row_end(s2_row_end), .s2_last(s2_last),
    .out_valid(out_valid), .out_data(out_data),
    .out_row_end(out_row_end), .out_last(out_last)
  );

endmodule

// ==== testbench/tb_oneplus_top.sv ====
// Directed testbench for the matrix oneplus unit
// Runs the DUT with default parameters DATA_SIZE 16 and OUT_CREDITS 4
// Source and sink obey the credit rules on both sides

`timescale 1ns/100ps

module tb_oneplus_top;

  localparam int DW          = 16;
  localparam int DIMW        = 8;
  localparam int CREDITS     = 4;
  localparam int MAX_POS     = 2**(DW-1) - 1;
  // Elements over all tests
  localparam int TOTAL_ELEMS = 8 + 20 + 2 + 9 + 6;
  localparam int LIMIT       = 20 * TOTAL_ELEMS + 500;

  logic            CLK = 1'b0;
  logic            RST;
  logic            start;
  logic [DIMW-1:0] rows;
  logic [DIMW-1:0] cols;
  logic            in_valid;
  logic [DW-1:0]   in_data;
  logic            out_credit;
  logic            in_credit;
  logic            out_valid;
  logic [DW-1:0]   out_data;
  logic            out_row_end;
  logic            out_last;
  logic            busy;
  logic            done;

  // Softplus residual per quarter bin of |x|, Q.8
  int res_tbl [16] = '{177, 147, 121, 99, 80, 64, 52, 41, 32, 26, 20, 16, 12, 10, 8, 6};

  ////////////////////////////////////////////////////////////////////////////
  // Model state
  ////////////////////////////////////////////////////////////////////////////

  logic [DW-1:0] src_q[$];
  int            sent_cyc[$];
  logic [DW-1:0] exp_data[$];
  logic          exp_row_end[$];
  logic          exp_last[$];
  int            cyc = 0;
  int            held = 0;
  int            owed = 0;
  int            credit_cnt = 0;
  int            done_cnt = 0;
  int            err_cnt = 0;
  logic          hold_credits = 1'b0;
  logic          zero_ok = 1'b0;
  logic          last_prev = 1'b0;
  integer        seed = 13;

  oneplus_top #(
    .DATA_SIZE  (DW),
    .DIM_WIDTH  (DIMW),
    .OUT_CREDITS(CREDITS)
  ) u_oneplus_top (
    .CLK(CLK), .RST(RST), .start(start), .rows(rows), .cols(cols),
    .in_valid(in_valid), .in_data(in_data), .out_credit(out_credit),
    .in_credit(in_credit), .out_valid(out_valid), .out_data(out_data),
    .out_row_end(out_row_end), .out_last(out_last), .busy(busy), .done(done)
  );

  always #20 CLK = ~CLK;

  task automatic abort_run(input string why);
    err_cnt++;
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got) begin
      abort_run($sformatf("ERR %s exp=%0h got=%0h", name, exp, got));
    end
  endtask

  // relu(x) + residual(|x|) + 1.0 clamped to the largest positive code
  function automatic logic [DW-1:0] ref_oneplus(input logic signed [DW-1:0] x);
    int v;
    int relu;
    int mag;
    int sum;
    v    = x;
    relu = (v > 0) ? v : 0;
    mag  = (v < 0) ? -v : v;
    sum  = relu + 256 + ((mag < 1024) ? res_tbl[mag / 64] : 0);
    if (sum > MAX_POS) begin
      sum = MAX_POS;
    end
    return sum[DW-1:0];
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Run limit, source and sink
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge CLK) begin
    cyc <= cyc + 1;
    if (cyc >= LIMIT) begin
      abort_run($sformatf("Timeout after %0d cycles", cyc));
    end
  end

  // Source spends each credit on the next prepared element
  always @(posedge CLK) begin
    if (!RST) begin
      if (in_credit) begin
        if (src_q.size() <= held) begin
          abort_run("Input credit granted with no element left to send");
        end
        held = held + 1;
        credit_cnt <= credit_cnt + 1;
      end
      if (held > 0) begin
        in_valid <= 1'b1;
        in_data  <= src_q.pop_front();
        sent_cyc.push_back(cyc);
        held = held - 1;
      end else begin
        in_valid <= 1'b0;
      end
    end
  end

  // Sink checks each output and returns or holds its slot
  always @(posedge CLK) begin
    if (!RST) begin
      if (out_valid) begin
        if (exp_data.size() == 0) begin
          abort_run("Output element appeared with no element sent");
        end
        check_val("out_data", exp_data.pop_front(), out_data);
        check_val("out_row_end", exp_row_end.pop_front(), out_row_end);
        check_val("out_last", exp_last.pop_front(), out_last);
        // Accepted one edge after the drive and out three edges later
        check_val("out_valid cycle", sent_cyc.pop_front() + 4, cyc);
        // Matrix still in progress while elements leave
        check_val("busy", 1, busy);
        owed = owed + 1;
      end
      if (!hold_credits && (owed > 0)) begin
        out_credit <= 1'b1;
        owed = owed - 1;
      end else begin
        out_credit <= 1'b0;
      end
      // done only on the edge after the last element
      if (done) begin
        done_cnt <= done_cnt + 1;
        if (!last_prev && !zero_ok) begin
          abort_run("done pulsed without a last element before it");
        end
        // busy falls on the edge that raises done
        check_val("busy", 0, busy);
      end else if (last_prev) begin
        abort_run("done missing on the edge after the last element");
      end
      last_prev = out_valid && out_last;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic push_elem(input logic [DW-1:0] val, input logic [DW-1:0] expv,
                           input int k, input int r, input int c);
    src_q.push_back(val);
    exp_data.push_back(expv);
    exp_row_end.push_back((k % c) == (c - 1));
    exp_last.push_back(k == (r * c - 1));
  endtask

  task automatic start_matrix(input int r, input int c);
    @(posedge CLK);
    start <= 1'b1;
    rows  <= r[DIMW-1:0];
    cols  <= c[DIMW-1:0];
    @(posedge CLK);
    start <= 1'b0;
  endtask

  task automatic finish_matrix(input int d0);
    int i;
    i = 0;
    while (done_cnt == d0) begin
      if (i == 400) begin
        abort_run("No done pulse at the end of the matrix");
      end
      @(posedge CLK);
      i++;
    end
    repeat (6) @(posedge CLK);
    check_val("done count", d0 + 1, done_cnt);
    check_val("busy", 0, busy);
    if (exp_data.size() != 0) begin
      abort_run("Matrix ended with output elements still missing");
    end
  endtask

  task automatic run_matrix(input int r, input int c);
    int d0;
    d0 = done_cnt;
    start_matrix(r, c);
    finish_matrix(d0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  // No start means no credit and no output
  task automatic test_idle_quiet();
    repeat (10) begin
      @(posedge CLK);
      check_val("out_valid", 0, out_valid);
      check_val("in_credit", 0, in_credit);
    end
  endtask

  task automatic test_known_points();
    int vin [8];
    int vexp [8];
    // 0, 1, -1, -3.9, 4, -4, 10, -10
    vin  = '{0, 256, -256, -998, 1024, -1024, 2560, -2560};
    vexp = '{433, 592, 336, 262, 1280, 256, 2816, 256};
    for (int k = 0; k < 8; k++) begin
      push_elem(vin[k][DW-1:0], vexp[k][DW-1:0], k, 1, 8);
    end
    run_matrix(1, 8);
  endtask

  task automatic test_random();
    logic [DW-1:0] v;
    for (int k = 0; k < 20; k++) begin
      // Mostly inside the table range of +-4
      v = $random(seed) % 2048;
      push_elem(v, ref_oneplus(v), k, 4, 5);
    end
    run_matrix(4, 5);
  endtask

  task automatic test_saturation();
    push_elem(MAX_POS, MAX_POS, 0, 1, 2);
    push_elem({1'b1, {(DW-1){1'b0}}}, 256, 1, 1, 2);
    run_matrix(1, 2);
  endtask

  task automatic test_back_pressure();
    int c0;
    int d0;
    logic [DW-1:0] v;
    hold_credits <= 1'b1;
    c0 = credit_cnt;
    d0 = done_cnt;
    for (int k = 0; k < 9; k++) begin
      v = (k - 4) * 300;
      push_elem(v, ref_oneplus(v), k, 3, 3);
    end
    start_matrix(3, 3);
    repeat (40) @(posedge CLK);
    if ((credit_cnt - c0) > CREDITS) begin
      abort_run("More input credits granted than output slots while the sink held them");
    end
    check_val("in_credit count", CREDITS, credit_cnt - c0);
    hold_credits <= 1'b0;
    finish_matrix(d0);
  endtask

  task automatic test_zero_dim();
    int c0;
    c0 = credit_cnt;
    zero_ok <= 1'b1;
    start_matrix(0, 3);
    @(posedge CLK);
    check_val("done", 1, done);
    repeat (10) @(posedge CLK);
    check_val("in_credit count", c0, credit_cnt);
    check_val("busy", 0, busy);
    zero_ok <= 1'b0;
  endtask

  // Second start mid-matrix must leave the 2x3 walk alone
  task automatic test_start_while_busy();
    int d0;
    logic [DW-1:0] v;
    d0 = done_cnt;
    for (int k = 0; k < 6; k++) begin
      v = $random(seed) % 1024;
      push_elem(v, ref_oneplus(v), k, 2, 3);
    end
    start_matrix(2, 3);
    repeat (3) @(posedge CLK);
    start_matrix(1, 1);
    finish_matrix(d0);
  endtask

  initial begin
    RST        = 1'b1;
    start      = 1'b0;
    rows       = '0;
    cols       = '0;
    in_valid   = 1'b0;
    in_data    = '0;
    out_credit = 1'b0;
    repeat (10) @(posedge CLK);
    RST <= 1'b0;
    repeat (2) @(posedge CLK);
    test_idle_quiet();
    test_known_points();
    test_random();
    test_saturation();
    test_back_pressure();
    test_zero_dim();
    test_start_while_busy();
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
hw/oneplus_pkg.sv
hw/oneplus_matrix_ctrl.sv
hw/oneplus_split.sv
hw/oneplus_residual.sv
hw/oneplus_sum.sv
hw/oneplus_top.sv
testbench/tb_oneplus_top.sv
